//--- project.f
hdl/tile_pkg.sv
hdl/slot_tracker.sv
hdl/status_regs.sv
hdl/dmem_shared.sv
hdl/desc_engine.sv
hdl/core_tile.sv
test/core_tile_assert.sv
test/core_tile_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= core_tile_tb
FILELIST  ?= project.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- test/core_tile_tb.sv
module core_tile_tb import tile_pkg::*; ();

  // Tests take about 1100 cycles, limit leaves plenty of margin
  localparam int cycle_limit = 4000;

  logic               clk;
  logic               rst_n;
  logic               dma_en;
  logic               dma_wen;
  logic [dmem_aw-1:0] dma_addr;
  logic [data_w-1:0]  dma_wr_data;
  logic               dma_ready;
  logic [data_w-1:0]  dma_rd_data;
  logic               dma_rd_valid;
  logic [desc_w-1:0]  in_desc;
  logic               in_desc_valid;
  logic               in_desc_taken;
  logic [desc_w-1:0]  out_desc;
  logic               out_desc_valid;
  logic               out_desc_ready;
  logic [msg_w-1:0]   bc_msg_in;
  logic               bc_msg_in_valid;
  logic [msg_w-1:0]   bc_msg_out;
  logic               bc_msg_out_valid;
  logic               bc_msg_out_ready;
  logic [2:0]         wrapper_status_addr;
  logic [data_w-1:0]  wrapper_status_data;
  logic [1:0]         core_status_addr;
  logic [data_w-1:0]  core_status_data;

  int                 seed;
  int                 ready_seed;
  int                 ready_mode;
  int                 cycles;
  logic               dma_rd_pend;
  logic [31:0]        model [dmem_words];
  logic [31:0]        act_model;
  logic               dupl_exp;
  logic               inv_exp;
  logic [7:0]         core_id_exp;
  logic [7:0]         max_cfg;
  logic [31:0]        dma_q [$];
  logic [31:0]        res_q [$];
  logic [msg_w-1:0]   msg_q [$];
  logic [desc_w-1:0]  desc_q [$];

  core_tile u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////
  // Reporting
  ////////////////////
  task automatic fail_run();
    $display("Checks failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    fail_run();
  endtask

  task automatic problem(input string what);
    $display("%0t: %s", $time, what);
    fail_run();
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  // Expected result word from descriptor type, operand and memory word
  function automatic logic [31:0] expected_result(input desc_type_e typ, input logic [15:0] op,
                                                  input logic [31:0] word);
    case (typ)
      DESC_ADD:   return word + {16'd0, op};
      DESC_BCAST: return word;
      default:    return '0;
    endcase
  endfunction

  ////////////////////
  // Stimulus tasks
  ////////////////////
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic dma_access(input logic wen, input logic [9:0] addr, input logic [31:0] data);
    logic ok;
    dma_en      = 1'b1;
    dma_wen     = wen;
    dma_addr    = addr;
    dma_wr_data = data;
    do begin
      @(negedge clk);
      ok = dma_ready;
      next_cycle();
    end while (!ok);
    dma_en = 1'b0;
  endtask

  task automatic offer_desc(input desc_type_e typ, input logic [4:0] slot,
                            input logic [9:0] addr, output logic [63:0] d, output logic ok);
    logic [15:0] op;
    logic [31:0] word;
    op        = 16'(rand32());
    d         = {rand32(), rand32()};
    d[63:60]  = typ;
    d[47:32]  = op;
    d[20:16]  = slot;
    d[9:0]    = addr;
    ok        = (slot != 5'd0) && ({3'b000, slot} <= max_cfg);
    if (ok) begin
      if (act_model[slot])
        dupl_exp = 1'b1;
      act_model[slot] = 1'b1;
      desc_q.push_back(d);
      if (typ == DESC_ADD || typ == DESC_BCAST) begin
        word = model[addr];
        res_q.push_back(expected_result(typ, op, word));
        if (typ == DESC_ADD)
          model[addr] = expected_result(typ, op, word);
        else
          msg_q.push_back({addr[5:0], 4'hf, word});
      end
    end else begin
      inv_exp = 1'b1;
    end
    in_desc       = d;
    in_desc_valid = 1'b1;
    do begin
      next_cycle();
    end while (!in_desc_taken);
    in_desc_valid = 1'b0;
  endtask

  task automatic finish_desc(input logic [63:0] d);
    do begin
      @(negedge clk);
    end while (!(out_desc_valid && out_desc_ready));
    if (d[63:60] != DESC_KEEP)
      act_model[d[20:16]] = 1'b0;
    next_cycle();
  endtask

  task automatic send_desc(input desc_type_e typ, input logic [4:0] slot,
                           input logic [9:0] addr);
    logic [63:0] d;
    logic        ok;
    offer_desc(typ, slot, addr, d, ok);
    if (ok) begin
      finish_desc(d);
    end else begin
      // Dropped descriptor must not come out
      repeat (3) begin
        @(negedge clk);
        assert (!out_desc_valid) else problem("out_desc sent for an invalid slot");
      end
      next_cycle();
    end
  endtask

  task automatic send_status(input stat_addr_e addr, input logic [31:0] data);
    wrapper_status_addr = addr;
    wrapper_status_data = data;
    next_cycle();
    wrapper_status_addr = STAT_NONE;
  endtask

  task automatic send_bcast_msg();
    bc_msg_in       = {6'(rand32()), 4'(rand32()), rand32()};
    bc_msg_in_valid = 1'b1;
    next_cycle();
    bc_msg_in_valid = 1'b0;
    repeat (2'(rand32())) next_cycle();
  endtask

  task automatic check_summary();
    logic [31:0] exp;
    repeat (2) @(posedge clk);
    do begin
      @(negedge clk);
    end while (core_status_addr != CSTAT_SUMMARY);
    exp = {core_id_exp, 2'b00, 6'($countones(act_model)), 14'd0, dupl_exp, inv_exp};
    assert (core_status_data == exp)
      else mismatch("core_status_data", 64'(exp), 64'(core_status_data));
    next_cycle();
  endtask

  task automatic wait_idle();
    while (dma_q.size() != 0 || res_q.size() != 0 || msg_q.size() != 0 || desc_q.size() != 0)
      next_cycle();
  endtask

  ////////////////////
  // Ready stalls and timeout
  ////////////////////
  always @(posedge clk) begin
    #1;
    case (ready_mode)
      1: begin
        out_desc_ready   = ($random(ready_seed) & 3) != 0;
        bc_msg_out_ready = ($random(ready_seed) & 3) != 0;
      end
      2: begin
        out_desc_ready   = 1'b0;
        bc_msg_out_ready = 1'b0;
      end
      default: begin
        out_desc_ready   = 1'b1;
        bc_msg_out_ready = 1'b1;
      end
    endcase
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit)
      problem("timeout, the run went past its cycle limit");
  end

  ////////////////////
  // Compare process
  ////////////////////
  always @(negedge clk) begin
    logic [31:0]      exp32;
    logic [msg_w-1:0] exp_msg;
    logic [63:0]      exp64;
    if (rst_n) begin
      // Read data is due one cycle after the accepted read
      assert (dma_rd_valid == dma_rd_pend)
        else mismatch("dma_rd_valid", 64'(dma_rd_pend), 64'(dma_rd_valid));
      if (dma_rd_valid) begin
        assert (dma_q.size() != 0) else problem("DMA read data with no read pending");
        exp32 = dma_q.pop_front();
        assert (dma_rd_data == exp32)
          else mismatch("dma_rd_data", 64'(exp32), 64'(dma_rd_data));
      end
      if (core_status_addr == CSTAT_RESULT) begin
        assert (res_q.size() != 0) else problem("result word with no descriptor pending");
        exp32 = res_q.pop_front();
        assert (core_status_data == exp32)
          else mismatch("core_status_data", 64'(exp32), 64'(core_status_data));
      end
      if (bc_msg_out_valid && bc_msg_out_ready) begin
        assert (msg_q.size() != 0) else problem("broadcast message with none expected");
        exp_msg = msg_q.pop_front();
        assert (bc_msg_out == exp_msg)
          else mismatch("bc_msg_out", 64'(exp_msg), 64'(bc_msg_out));
      end
      if (out_desc_valid && out_desc_ready) begin
        assert (desc_q.size() != 0) else problem("out_desc with no descriptor pending");
        exp64 = desc_q.pop_front();
        assert (out_desc == exp64) else mismatch("out_desc", exp64, out_desc);
      end
      // Memory model follows the accepted writes, reads take a snapshot
      if (bc_msg_in_valid) begin
        assert (!dma_ready) else problem("dma_ready high during a broadcast write");
        for (int b = 0; b < 4; b++) begin
          if (bc_msg_in[32+b])
            model[{4'hf, bc_msg_in[41:36]}][b*8 +: 8] = bc_msg_in[b*8 +: 8];
        end
      end
      if (dma_en && dma_ready) begin
        if (dma_wen)
          model[dma_addr] = dma_wr_data;
        else
          dma_q.push_back(model[dma_addr]);
      end
      dma_rd_pend = dma_en && dma_ready && !dma_wen;
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////
  initial begin
    logic [63:0] d;
    logic        ok;
    logic [9:0]  addr;
    seed                = 23212;
    ready_seed          = 23212;
    ready_mode          = 0;
    cycles              = 0;
    dma_rd_pend         = 1'b0;
    act_model           = '0;
    dupl_exp            = 1'b0;
    inv_exp             = 1'b0;
    core_id_exp         = '0;
    max_cfg             = '0;
    rst_n               = 1'b0;
    dma_en              = 1'b0;
    dma_wen             = 1'b0;
    dma_addr            = '0;
    dma_wr_data         = '0;
    in_desc             = '0;
    in_desc_valid       = 1'b0;
    out_desc_ready      = 1'b1;
    bc_msg_in           = '0;
    bc_msg_in_valid     = 1'b0;
    bc_msg_out_ready    = 1'b1;
    wrapper_status_addr = STAT_NONE;
    wrapper_status_data = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_summary();

    core_id_exp = 8'(rand32());
    max_cfg     = 8'd20;
    send_status(STAT_CONFIG, {core_id_exp, 16'd0, max_cfg});
    check_summary();

    // DMA fill of the low words, then random readback
    for (int i = 0; i < 128; i++)
      dma_access(1'b1, 10'(i), rand32());
    repeat (64) dma_access(1'b0, {3'b000, 7'(rand32())}, '0);
    wait_idle();

    // ADD with readback of the sum
    for (int i = 0; i < 16; i++) begin
      addr = {3'b000, 7'(rand32())};
      send_desc(DESC_ADD, 5'(i + 1), addr);
      dma_access(1'b0, addr, '0);
    end
    wait_idle();
    check_summary();

    // BCAST under random ready stalls
    ready_mode = 1;
    for (int i = 0; i < 16; i++)
      send_desc(DESC_BCAST, 5'(i + 1), {3'b000, 7'(rand32())});
    ready_mode = 0;
    wait_idle();

    // Broadcast writes racing DMA reads of the region
    for (int i = 960; i < 1024; i++)
      dma_access(1'b1, 10'(i), rand32());
    fork
      repeat (32) send_bcast_msg();
      repeat (48) dma_access(1'b0, {4'hf, 6'(rand32())}, '0);
    join
    for (int i = 960; i < 1024; i++)
      dma_access(1'b0, 10'(i), '0);
    wait_idle();

    // Slot tracking and error flags
    send_desc(DESC_KEEP, 5'd3, 10'd0);
    check_summary();
    send_desc(DESC_KEEP, 5'd5, 10'd0);
    check_summary();
    ready_mode = 2;
    offer_desc(DESC_ADD, 5'd9, 10'd12, d, ok);
    check_summary();
    ready_mode = 0;
    finish_desc(d);
    check_summary();
    send_desc(DESC_DROP, 5'd3, 10'd0);
    check_summary();
    send_desc(DESC_BCAST, 5'd5, 10'd40);
    check_summary();
    send_desc(DESC_ADD, 5'd0, 10'd1);
    check_summary();
    send_desc(DESC_KEEP, 5'd25, 10'd1);
    check_summary();
    send_status(STAT_CLEAR_ERR, '0);
    dupl_exp = 1'b0;
    inv_exp  = 1'b0;
    check_summary();

    core_id_exp = 8'(rand32());
    send_status(STAT_CONFIG, {core_id_exp, 16'd0, max_cfg});
    check_summary();
    wait_idle();

    $display("All checks passed");
    $finish;
  end

endmodule

//--- test/core_tile_assert.sv
module core_tile_assert import tile_pkg::*; (
  input logic              clk,
  input logic              rst_n,
  input logic              in_desc_taken,
  input logic [desc_w-1:0] out_desc,
  input logic              out_desc_valid,
  input logic              out_desc_ready,
  input logic [msg_w-1:0]  bc_msg_out,
  input logic              bc_msg_out_valid,
  input logic              bc_msg_out_ready,
  input logic              bc_msg_in_valid,
  input logic              dma_ready
);

  // One pulse per accepted descriptor
  taken_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    in_desc_taken |=> !in_desc_taken)
    else $error("in_desc_taken lasted more than one cycle");

  out_desc_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_desc_valid && !out_desc_ready |=> out_desc_valid && $stable(out_desc))
    else $error("out_desc dropped or changed before out_desc_ready");

  bc_msg_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bc_msg_out_valid && !bc_msg_out_ready |=> bc_msg_out_valid && $stable(bc_msg_out))
    else $error("bc_msg_out dropped or changed before bc_msg_out_ready");

  // Broadcast writes own the memory port
  dma_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    bc_msg_in_valid |-> !dma_ready)
    else $error("dma_ready high while bc_msg_in_valid is high");

endmodule

bind core_tile core_tile_assert u_assert (.*);

//--- hdl/core_tile.sv
module core_tile import tile_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,

  // DMA port
  input  logic               dma_en,
  input  logic               dma_wen,
  input  logic [dmem_aw-1:0] dma_addr,
  input  logic [data_w-1:0]  dma_wr_data,
  output logic               dma_ready,
  output logic [data_w-1:0]  dma_rd_data,
  output logic               dma_rd_valid,

  // Descriptors
  input  logic [desc_w-1:0]  in_desc,
  input  logic               in_desc_valid,
  output logic               in_desc_taken,
  output logic [desc_w-1:0]  out_desc,
  output logic               out_desc_valid,
  input  logic               out_desc_ready,

  // Broadcast messages
  input  logic [msg_w-1:0]   bc_msg_in,
  input  logic               bc_msg_in_valid,
  output logic [msg_w-1:0]   bc_msg_out,
  output logic               bc_msg_out_valid,
  input  logic               bc_msg_out_ready,

  // Status channels
  input  logic [2:0]         wrapper_status_addr,
  input  logic [data_w-1:0]  wrapper_status_data,
  output logic [1:0]         core_status_addr,
  output logic [data_w-1:0]  core_status_data
);

  logic               slot_invalid;
  logic [slot_w:0]    active_count;
  logic               dupl_err;
  logic               inv_err;
  logic [cfg_w-1:0]   core_id;
  logic [cfg_w-1:0]   max_slot_count;
  logic               clear_err;
  logic               result_valid;
  logic [data_w-1:0]  result;
  logic               eng_en;
  logic               eng_wen;
  logic [dmem_aw-1:0] eng_addr;
  logic [data_w-1:0]  eng_wr_data;
  logic               eng_gnt;
  logic [data_w-1:0]  eng_rd_data;
  logic               eng_rd_valid;

  slot_tracker u_slot_tracker (
    .clk            (clk),
    .rst_n          (rst_n),
    .desc_taken     (in_desc_taken),
    .in_slot        (in_desc[desc_slot_hi:desc_slot_lo]),
    .max_slot_count (max_slot_count),
    .out_desc       (out_desc),
    .out_desc_valid (out_desc_valid),
    .out_desc_ready (out_desc_ready),
    .clear_err      (clear_err),
    .slot_invalid   (slot_invalid),
    .active_count   (active_count),
    .dupl_err       (dupl_err),
    .inv_err        (inv_err)
  );

  status_regs u_status_regs (
    .clk                 (clk),
    .rst_n               (rst_n),
    .wrapper_status_addr (wrapper_status_addr),
    .wrapper_status_data (wrapper_status_data),
    .result_valid        (result_valid),
    .result              (result),
    .active_count        (active_count),
    .dupl_err            (dupl_err),
    .inv_err             (inv_err),
    .core_id             (core_id),
    .max_slot_count      (max_slot_count),
    .clear_err           (clear_err),
    .core_status_addr    (core_status_addr),
    .core_status_data    (core_status_data)
  );

  dmem_shared u_dmem_shared (
    .clk             (clk),
    .rst_n           (rst_n),
    .bc_msg_in       (bc_msg_in),
    .bc_msg_in_valid (bc_msg_in_valid),
    .dma_en          (dma_en),
    .dma_wen         (dma_wen),
    .dma_addr        (dma_addr),
    .dma_wr_data     (dma_wr_data),
    .dma_ready       (dma_ready),
    .dma_rd_data     (dma_rd_data),
    .dma_rd_valid    (dma_rd_valid),
    .eng_en          (eng_en),
    .eng_wen         (eng_wen),
    .eng_addr        (eng_addr),
    .eng_wr_data     (eng_wr_data),
    .eng_gnt         (eng_gnt),
    .eng_rd_data     (eng_rd_data),
    .eng_rd_valid    (eng_rd_valid)
  );

  desc_engine u_desc_engine (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_desc          (in_desc),
    .in_desc_valid    (in_desc_valid),
    .in_desc_taken    (in_desc_taken),
    .slot_invalid     (slot_invalid),
    .out_desc         (out_desc),
    .out_desc_valid   (out_desc_valid),
    .out_desc_ready   (out_desc_ready),
    .bc_msg_out       (bc_msg_out),
    .bc_msg_out_valid (bc_msg_out_valid),
    .bc_msg_out_ready (bc_msg_out_ready),
    .eng_en           (eng_en),
    .eng_wen          (eng_wen),
    .eng_addr         (eng_addr),
    .eng_wr_data      (eng_wr_data),
    .eng_gnt          (eng_gnt),
    .eng_rd_data      (eng_rd_data),
    .eng_rd_valid     (eng_rd_valid),
    .result_valid     (result_valid),
    .result           (result)
  );

endmodule

//--- hdl/desc_engine.sv
module desc_engine import tile_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [desc_w-1:0]  in_desc,
  input  logic               in_desc_valid,
  output logic               in_desc_taken,
  input  logic               slot_invalid,
  output logic [desc_w-1:0]  out_desc,
  output logic               out_desc_valid,
  input  logic               out_desc_ready,
  output logic [msg_w-1:0]   bc_msg_out,
  output logic               bc_msg_out_valid,
  input  logic               bc_msg_out_ready,
  output logic               eng_en,
  output logic               eng_wen,
  output logic [dmem_aw-1:0] eng_addr,
  output logic [data_w-1:0]  eng_wr_data,
  input  logic               eng_gnt,
  input  logic [data_w-1:0]  eng_rd_data,
  input  logic               eng_rd_valid,
  output logic               result_valid,
  output logic [data_w-1:0]  result
);

  eng_state_e        state;
  logic [desc_w-1:0] desc_q;
  logic [data_w-1:0] word_q;
  desc_type_e        in_type;
  desc_type_e        cur_type;
  logic [data_w-1:0] operand;
  logic [data_w-1:0] sum;
  logic              accept;

  assign in_type  = desc_type_e'(in_desc[desc_type_hi:desc_type_lo]);
  assign cur_type = desc_type_e'(desc_q[desc_type_hi:desc_type_lo]);
  assign operand  = {{(data_w-(desc_op_hi-desc_op_lo+1)){1'b0}},
                     desc_q[desc_op_hi:desc_op_lo]};
  // Wraps modulo 2**32
  assign sum      = word_q + operand;

  // Taken guard keeps the same descriptor from being accepted twice
  assign accept = (state == ENG_IDLE) && in_desc_valid && !in_desc_taken;

  always_ff @(posedge clk) begin
    if (accept)
      desc_q <= in_desc;
    if (state == ENG_WAIT && eng_rd_valid)
      word_q <= eng_rd_data;
  end

  //////////////////////
  // Descriptor FSM
  //////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= ENG_IDLE;
      in_desc_taken <= 1'b0;
      result_valid  <= 1'b0;
    end else begin
      in_desc_taken <= 1'b0;
      result_valid  <= 1'b0;
      case (state)
        ENG_IDLE: begin
          if (accept) begin
            in_desc_taken <= 1'b1;
            // Invalid slot is dropped here with no out_desc
            if (!slot_invalid) begin
              if (in_type == DESC_ADD || in_type == DESC_BCAST)
                state <= ENG_REQ;
              else
                state <= ENG_DONE;
            end
          end
        end
        ENG_REQ: begin
          if (eng_gnt)
            state <= ENG_WAIT;
        end
        ENG_WAIT: begin
          if (eng_rd_valid)
            state <= (cur_type == DESC_ADD) ? ENG_WRITE : ENG_MSG;
        end
        ENG_WRITE: begin
          if (eng_gnt) begin
            state        <= ENG_DONE;
            result_valid <= 1'b1;
          end
        end
        ENG_MSG: begin
          if (bc_msg_out_ready) begin
            state        <= ENG_DONE;
            result_valid <= 1'b1;
          end
        end
        ENG_DONE: begin
          if (out_desc_ready)
            state <= ENG_IDLE;
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

  // Memory request held until granted
  assign eng_en      = (state == ENG_REQ) || (state == ENG_WRITE);
  assign eng_wen     = (state == ENG_WRITE);
  assign eng_addr    = desc_q[desc_addr_hi:desc_addr_lo];
  assign eng_wr_data = sum;

  // Full word message, offset from the low address bits
  assign bc_msg_out       = {desc_q[bc_aw-1:0], {strb_w{1'b1}}, word_q};
  assign bc_msg_out_valid = (state == ENG_MSG);

  assign out_desc       = desc_q;
  assign out_desc_valid = (state == ENG_DONE);

  assign result = (cur_type == DESC_ADD) ? sum : word_q;

endmodule

//--- hdl/dmem_shared.sv
module dmem_shared import tile_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,

  // Broadcast writes
  input  logic [msg_w-1:0]   bc_msg_in,
  input  logic               bc_msg_in_valid,

  // DMA port
  input  logic               dma_en,
  input  logic               dma_wen,
  input  logic [dmem_aw-1:0] dma_addr,
  input  logic [data_w-1:0]  dma_wr_data,
  output logic               dma_ready,
  output logic [data_w-1:0]  dma_rd_data,
  output logic               dma_rd_valid,

  // Descriptor engine port
  input  logic               eng_en,
  input  logic               eng_wen,
  input  logic [dmem_aw-1:0] eng_addr,
  input  logic [data_w-1:0]  eng_wr_data,
  output logic               eng_gnt,
  output logic [data_w-1:0]  eng_rd_data,
  output logic               eng_rd_valid
);

  logic [data_w-1:0]  mem [dmem_words];
  logic [data_w-1:0]  rd_q;
  logic [data_w-1:0]  bc_data;
  logic [strb_w-1:0]  bc_strb;
  logic [bc_aw-1:0]   bc_off;
  logic               dma_sel;
  logic               eng_sel;
  logic               mem_wen;
  logic               mem_ren;
  logic [strb_w-1:0]  mem_strb;
  logic [dmem_aw-1:0] mem_addr;
  logic [data_w-1:0]  mem_wr_data;

  // Message is offset, strobe, data from the top down
  assign bc_data = bc_msg_in[data_w-1:0];
  assign bc_strb = bc_msg_in[data_w+strb_w-1:data_w];
  assign bc_off  = bc_msg_in[msg_w-1:data_w+strb_w];

  //////////////////////
  // Fixed priority
  //////////////////////
  assign dma_ready = !bc_msg_in_valid;
  assign dma_sel   = dma_en && dma_ready;
  assign eng_sel   = eng_en && !bc_msg_in_valid && !dma_sel;
  assign eng_gnt   = eng_sel;

  always_comb begin
    mem_wen     = 1'b0;
    mem_ren     = 1'b0;
    mem_strb    = {strb_w{1'b1}};
    mem_addr    = eng_addr;
    mem_wr_data = eng_wr_data;
    if (bc_msg_in_valid) begin
      // Broadcast region sits at the top of the memory
      mem_wen     = 1'b1;
      mem_strb    = bc_strb;
      mem_addr    = {{(dmem_aw-bc_aw){1'b1}}, bc_off};
      mem_wr_data = bc_data;
    end else if (dma_sel) begin
      mem_wen     = dma_wen;
      mem_ren     = !dma_wen;
      mem_addr    = dma_addr;
      mem_wr_data = dma_wr_data;
    end else if (eng_sel) begin
      mem_wen = eng_wen;
      mem_ren = !eng_wen;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_wen) begin
      for (int b = 0; b < strb_w; b++) begin
        if (mem_strb[b])
          mem[mem_addr][b*8 +: 8] <= mem_wr_data[b*8 +: 8];
      end
    end
    if (mem_ren)
      rd_q <= mem[mem_addr];
  end

  // Read owner follows the data by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dma_rd_valid <= 1'b0;
      eng_rd_valid <= 1'b0;
    end else begin
      dma_rd_valid <= dma_sel && !dma_wen;
      eng_rd_valid <= eng_sel && !eng_wen;
    end
  end

  assign dma_rd_data = rd_q;
  assign eng_rd_data = rd_q;

endmodule

//--- hdl/status_regs.sv
module status_regs import tile_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [2:0]        wrapper_status_addr,
  input  logic [data_w-1:0] wrapper_status_data,
  input  logic              result_valid,
  input  logic [data_w-1:0] result,
  input  logic [slot_w:0]   active_count,
  input  logic              dupl_err,
  input  logic              inv_err,
  output logic [cfg_w-1:0]  core_id,
  output logic [cfg_w-1:0]  max_slot_count,
  output logic              clear_err,
  output logic [1:0]        core_status_addr,
  output logic [data_w-1:0] core_status_data
);

  logic [data_w-1:0] summary;

  //////////////////////
  // Wrapper to core
  //////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      core_id        <= '0;
      max_slot_count <= '0;
      clear_err      <= 1'b0;
    end else begin
      clear_err <= 1'b0;
      case (wrapper_status_addr)
        STAT_CONFIG: begin
          core_id        <= wrapper_status_data[31:24];
          max_slot_count <= wrapper_status_data[7:0];
        end
        STAT_CLEAR_ERR: begin
          clear_err <= 1'b1;
        end
        // STAT_NONE and unused addresses
        default: begin
        end
      endcase
    end
  end

  //////////////////////
  // Core to wrapper
  //////////////////////
  assign summary = {core_id, 2'b00, active_count, 14'd0, dupl_err, inv_err};

  // Result word wins over the summary for its one cycle
  assign core_status_addr = result_valid ? CSTAT_RESULT : CSTAT_SUMMARY;
  assign core_status_data = result_valid ? result : summary;

endmodule

//--- hdl/slot_tracker.sv
module slot_tracker import tile_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              desc_taken,
  input  logic [slot_w-1:0] in_slot,
  input  logic [cfg_w-1:0]  max_slot_count,
  input  logic [desc_w-1:0] out_desc,
  input  logic              out_desc_valid,
  input  logic              out_desc_ready,
  input  logic              clear_err,
  output logic              slot_invalid,
  output logic [slot_w:0]   active_count,
  output logic              dupl_err,
  output logic              inv_err
);

  logic [max_slots:1]                 active;
  logic [desc_type_hi-desc_type_lo:0] out_type;
  logic [slot_w-1:0]                  done_slot;
  logic                               done;

  // Release on the out_desc handshake, KEEP holds its slot
  assign out_type  = out_desc[desc_type_hi:desc_type_lo];
  assign done_slot = out_desc[desc_slot_hi:desc_slot_lo];
  assign done      = out_desc_valid && out_desc_ready &&
                     (out_type == DESC_ADD || out_type == DESC_BCAST ||
                      out_type == DESC_DROP);

  assign slot_invalid = (in_slot == '0) ||
                        ({{(cfg_w-slot_w){1'b0}}, in_slot} > max_slot_count);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active <= '0;
    end else begin
      if (desc_taken && !slot_invalid)
        active[in_slot] <= 1'b1;
      // Clear last so a same-cycle DROP leaves the slot free
      if (done)
        active[done_slot] <= 1'b0;
    end
  end

  // Sticky error flags
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dupl_err <= 1'b0;
      inv_err  <= 1'b0;
    end else begin
      if (clear_err) begin
        dupl_err <= 1'b0;
        inv_err  <= 1'b0;
      end
      if (desc_taken && slot_invalid)
        inv_err <= 1'b1;
      if (desc_taken && !slot_invalid && active[in_slot])
        dupl_err <= 1'b1;
    end
  end

  always_comb begin
    active_count = '0;
    for (int i = 1; i <= max_slots; i++)
      active_count = active_count + (slot_w+1)'(active[i]);
  end

endmodule

//--- hdl/tile_pkg.sv
package tile_pkg;

  //////////////////////
  // Widths and memory map
  //////////////////////
  localparam int data_w     = 32;
  localparam int strb_w     = data_w / 8;
  localparam int dmem_words = 1024;
  localparam int dmem_aw    = 10;
  localparam int bc_aw      = 6;
  localparam int msg_w      = data_w + strb_w + bc_aw;
  localparam int slot_w     = 5;
  localparam int max_slots  = 31;
  localparam int desc_w     = 64;
  // core_id and max_slot_count
  localparam int cfg_w      = 8;

  //////////////////////
  // Descriptor fields
  //////////////////////
  localparam int desc_type_hi = 63;
  localparam int desc_type_lo = 60;
  localparam int desc_op_hi   = 47;
  localparam int desc_op_lo   = 32;
  localparam int desc_slot_hi = 20;
  localparam int desc_slot_lo = 16;
  localparam int desc_addr_hi = dmem_aw - 1;
  localparam int desc_addr_lo = 0;

  typedef enum logic [3:0] {
    DESC_ADD   = 4'd0,
    DESC_BCAST = 4'd1,
    DESC_DROP  = 4'd2,
    DESC_KEEP  = 4'd3
  } desc_type_e;

  typedef enum logic [2:0] {
    STAT_NONE      = 3'd0,
    STAT_CONFIG    = 3'd1,
    STAT_CLEAR_ERR = 3'd2
  } stat_addr_e;

  typedef enum logic [1:0] {
    CSTAT_SUMMARY = 2'd0,
    CSTAT_RESULT  = 2'd1
  } core_stat_e;

  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_REQ,
    ENG_WAIT,
    ENG_WRITE,
    ENG_MSG,
    ENG_DONE
  } eng_state_e;

endpackage
